/* rtl/game_pkg.sv */
package game_pkg;

    typedef enum logic [2:0] {
        START,
        KEEPER,
        SHOOTER,
        WINNER,
        LOSER
    } g_state;

    typedef enum logic {
        SOLO,
        MULTI
    } g_mode;

    // Goal and shot counts
    typedef logic [3:0] score_t;

    // Byte sent to the link partner every cycle
    typedef logic [7:0] sync_byte_t;

    // Shot window counter, wide enough to hold SHOT_TICKS
    typedef logic [4:0] tick_t;

    localparam tick_t SHOT_TICKS = 5'd16;

    localparam score_t MATCH_SHOTS = 4'd6;

    // A solo player wins by conceding fewer goals than this
    localparam score_t SOLO_MAX_CONCEDED = 4'd2;

    localparam sync_byte_t SYNC_CLICK = 8'hC8;
    localparam sync_byte_t SYNC_START = 8'h48;
    localparam sync_byte_t SYNC_IDLE  = 8'h08;

endpackage

/* rtl/shot_if.sv */
`timescale 1ns/100ps

interface shot_if import game_pkg::*; ();

    g_state game_state;
    logic   shot_done;
    logic   shot_goal;
    logic   match_end;
    logic   match_result;

    modport fsm (
        output game_state,
        input  shot_done, match_end, match_result
    );

    modport timer (
        input  game_state,
        output shot_done, shot_goal
    );

    modport scorer (
        input  game_state, shot_done, shot_goal,
        output match_end, match_result
    );

endinterface

/* rtl/game_state_sel.sv */
`timescale 1ns/100ps

module game_state_sel import game_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       left_clicked,
    input  logic       right_clicked,
    input  logic       solo_enable,
    input  logic       connect_corrected,
    input  logic       enemy_shooter,
    input  logic       game_starts,
    shot_if.fsm        shots,
    output sync_byte_t data_to_transmit,
    output g_mode      game_mode
);

    g_state     game_state;
    g_state     game_state_nxt;
    g_mode      game_mode_nxt;
    sync_byte_t data_to_transmit_nxt;
    g_state     end_state;

    assign shots.game_state = game_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= START;
            game_mode  <= MULTI;
        end else begin
            game_state <= game_state_nxt;
            game_mode  <= game_mode_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_to_transmit <= '0;
        end else begin
            data_to_transmit <= data_to_transmit_nxt;
        end
    end

    always_comb begin
        if (left_clicked) begin
            data_to_transmit_nxt = SYNC_CLICK;
        end else if (game_starts) begin
            data_to_transmit_nxt = SYNC_START;
        end else begin
            data_to_transmit_nxt = SYNC_IDLE;
        end
    end

    // The mode is latched while waiting in START and frozen for the whole match
    always_comb begin
        if (game_state == START) begin
            game_mode_nxt = solo_enable ? SOLO : MULTI;
        end else begin
            game_mode_nxt = game_mode;
        end
    end

    assign end_state = shots.match_result ? WINNER : LOSER;

    // Transitions use the mode being selected, so leaving START already obeys
    // the mode the match is played in
    always_comb begin
        game_state_nxt = game_state;
        if (game_mode_nxt == MULTI && !connect_corrected) begin
            game_state_nxt = START;
        end else begin
            case (game_state)
                START: begin
                    if (game_mode_nxt == SOLO) begin
                        if (left_clicked) begin
                            game_state_nxt = KEEPER;
                        end
                    end else if (game_starts) begin
                        game_state_nxt = enemy_shooter ? SHOOTER : KEEPER;
                    end
                end
                KEEPER: begin
                    if (shots.match_end) begin
                        game_state_nxt = end_state;
                    end else if (shots.shot_done && game_mode_nxt == MULTI) begin
                        game_state_nxt = SHOOTER;
                    end
                end
                SHOOTER: begin
                    if (shots.match_end) begin
                        game_state_nxt = end_state;
                    end else if (shots.shot_done) begin
                        game_state_nxt = KEEPER;
                    end
                end
                WINNER, LOSER: begin
                    if (right_clicked) begin
                        game_state_nxt = START;
                    end
                end
                default: begin
                    game_state_nxt = START;
                end
            endcase
        end
    end

    // A solo player only ever keeps goal
    assert property (@(posedge clk) disable iff (rst)
        !(game_state == SHOOTER && game_mode == SOLO));

    assert property (@(posedge clk) disable iff (rst)
        (game_state != START) |=> $stable(game_mode));

endmodule

/* rtl/shot_timer.sv */
`timescale 1ns/100ps

module shot_timer import game_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic shot_taken,
    input  logic shot_scored,
    shot_if.timer shots
);

    tick_t  window_cnt;
    g_state prev_state;
    logic   active;
    logic   entry;
    logic   resolve;

    assign active = (shots.game_state == KEEPER) || (shots.game_state == SHOOTER);
    assign entry  = shots.game_state != prev_state;

    // A shot attempt or an expired window resolves the shot. Nothing resolves
    // in the pulse cycle, as the state has not yet moved on
    assign resolve = active && !shots.shot_done &&
        (shot_taken || (!entry && window_cnt == SHOT_TICKS - tick_t'(1)));

    always_ff @(posedge clk) begin
        if (rst) begin
            window_cnt      <= '0;
            prev_state      <= START;
            shots.shot_done <= 1'b0;
            shots.shot_goal <= 1'b0;
        end else begin
            prev_state      <= shots.game_state;
            shots.shot_done <= resolve;
            shots.shot_goal <= resolve && shot_taken && shot_scored;
            if (!active || resolve) begin
                window_cnt <= '0;
            end else if (entry) begin
                // First cycle of a new state opens a fresh window
                window_cnt <= tick_t'(1);
            end else begin
                window_cnt <= window_cnt + tick_t'(1);
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        shots.shot_done |=> !shots.shot_done);

endmodule

/* rtl/match_scorer.sv */
`timescale 1ns/100ps

module match_scorer import game_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    shot_if.scorer shots,
    output score_t goals_own,
    output score_t goals_enemy
);

    score_t shot_cnt;
    logic   shooter_seen;
    logic   solo_rule;
    logic   count_shot;

    // Late resolutions after the last shot of a match are dropped
    assign count_shot = shots.shot_done && !shots.match_end;

    always_ff @(posedge clk) begin
        if (rst || shots.game_state == START) begin
            shot_cnt     <= '0;
            goals_own    <= '0;
            goals_enemy  <= '0;
            shooter_seen <= 1'b0;
        end else if (count_shot) begin
            shot_cnt <= shot_cnt + score_t'(1);
            if (shots.game_state == SHOOTER) begin
                shooter_seen <= 1'b1;
                if (shots.shot_goal) begin
                    goals_own <= goals_own + score_t'(1);
                end
            end
            if (shots.game_state == KEEPER && shots.shot_goal) begin
                goals_enemy <= goals_enemy + score_t'(1);
            end
        end
    end

    assign shots.match_end = shot_cnt == MATCH_SHOTS;

    // Solo play never reaches SHOOTER, so a match without any shooter turn
    // and no own goals is judged on goals conceded
    assign solo_rule = !shooter_seen && goals_own == '0;

    always_comb begin
        if (solo_rule) begin
            shots.match_result = goals_enemy < SOLO_MAX_CONCEDED;
        end else begin
            // A tie counts as a loss
            shots.match_result = goals_own > goals_enemy;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        shot_cnt <= MATCH_SHOTS);

endmodule

/* rtl/game_core.sv */
`timescale 1ns/100ps

module game_core import game_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       left_clicked,
    input  logic       right_clicked,
    input  logic       solo_enable,
    input  logic       connect_corrected,
    input  logic       enemy_shooter,
    input  logic       game_starts,
    input  logic       shot_taken,
    input  logic       shot_scored,
    output sync_byte_t data_to_transmit,
    output g_state     game_state,
    output g_mode      game_mode,
    output score_t     goals_own,
    output score_t     goals_enemy
);

    shot_if shots ();

    game_state_sel u_game_state_sel (
        .clk               (clk),
        .rst               (rst),
        .left_clicked      (left_clicked),
        .right_clicked     (right_clicked),
        .solo_enable       (solo_enable),
        .connect_corrected (connect_corrected),
        .enemy_shooter     (enemy_shooter),
        .game_starts       (game_starts),
        .shots             (shots.fsm),
        .data_to_transmit  (data_to_transmit),
        .game_mode         (game_mode)
    );

    shot_timer u_shot_timer (
        .clk         (clk),
        .rst         (rst),
        .shot_taken  (shot_taken),
        .shot_scored (shot_scored),
        .shots       (shots.timer)
    );

    match_scorer u_match_scorer (
        .clk         (clk),
        .rst         (rst),
        .shots       (shots.scorer),
        .goals_own   (goals_own),
        .goals_enemy (goals_enemy)
    );

    assign game_state = shots.game_state;

endmodule

/* dv/game_core_tb.sv */
`timescale 1ns/100ps

module game_core_tb import game_pkg::*; ();

    // Longest test is about 60 cycles, so this leaves a wide margin
    localparam int CYCLE_LIMIT = 3000;

    logic       clk;
    logic       rst;
    logic       left_clicked;
    logic       right_clicked;
    logic       solo_enable;
    logic       connect_corrected;
    logic       enemy_shooter;
    logic       game_starts;
    logic       shot_taken;
    logic       shot_scored;
    sync_byte_t data_to_transmit;
    g_state     game_state;
    g_mode      game_mode;
    score_t     goals_own;
    score_t     goals_enemy;

    int         mismatches;
    int         failures;
    int         cycles;
    logic [7:0] lfsr_state;

    game_core UUT (
        .clk               (clk),
        .rst               (rst),
        .left_clicked      (left_clicked),
        .right_clicked     (right_clicked),
        .solo_enable       (solo_enable),
        .connect_corrected (connect_corrected),
        .enemy_shooter     (enemy_shooter),
        .game_starts       (game_starts),
        .shot_taken        (shot_taken),
        .shot_scored       (shot_scored),
        .data_to_transmit  (data_to_transmit),
        .game_state        (game_state),
        .game_mode         (game_mode),
        .goals_own         (goals_own),
        .goals_enemy       (goals_enemy)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return (s >> 1) ^ (s[0] ? 8'hB8 : 8'h00);
    endfunction

    task automatic check_state(input g_state got, input g_state exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(),
                exp.name());
        end
    endtask

    task automatic check_mode(input g_mode got, input g_mode exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(),
                exp.name());
        end
    endtask

    task automatic check_score(input score_t got, input score_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input sync_byte_t got, input sync_byte_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    // One goal bit per LFSR step, bit i is the goal flag of shot i
    task automatic draw_goals(output logic [5:0] goals);
        for (int i = 0; i < 6; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            goals[i] = lfsr_state[0];
        end
    endtask

    task automatic click_left();
        @(posedge clk);
        left_clicked <= 1'b1;
        @(posedge clk);
        left_clicked <= 1'b0;
        @(negedge clk);
    endtask

    task automatic click_right();
        @(posedge clk);
        right_clicked <= 1'b1;
        @(posedge clk);
        right_clicked <= 1'b0;
        @(negedge clk);
    endtask

    // Returns after the edge where the state and scores take the shot
    task automatic take_shot(input logic goal);
        @(posedge clk);
        shot_taken  <= 1'b1;
        shot_scored <= goal;
        @(posedge clk);
        shot_taken  <= 1'b0;
        shot_scored <= 1'b0;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_state(input g_state target, input int bound);
        int n;
        n = 0;
        while (game_state !== target && n < bound) begin
            @(posedge clk);
            @(negedge clk);
            n++;
        end
        if (game_state !== target) begin
            failures++;
            $display("Error at %0t: state %s was not reached within %0d cycles", $time,
                target.name(), bound);
        end
    endtask

    task automatic start_multi(input logic shooter_first);
        @(posedge clk);
        solo_enable       <= 1'b0;
        connect_corrected <= 1'b1;
        enemy_shooter     <= shooter_first;
        game_starts       <= 1'b1;
        @(posedge clk);
        game_starts <= 1'b0;
        @(negedge clk);
        check_state(game_state, shooter_first ? SHOOTER : KEEPER, "state after start");
        check_mode(game_mode, MULTI, "mode after start");
    endtask

    task automatic test_reset();
        check_state(game_state, START, "state after reset");
        check_mode(game_mode, MULTI, "mode after reset");
        check_byte(data_to_transmit, 8'h00, "sync byte after reset");
        check_score(goals_own, 0, "goals_own after reset");
        check_score(goals_enemy, 0, "goals_enemy after reset");
    endtask

    task automatic send_sync(input logic lc, input logic gs, input sync_byte_t exp);
        @(posedge clk);
        left_clicked <= lc;
        game_starts  <= gs;
        @(posedge clk);
        left_clicked <= 1'b0;
        game_starts  <= 1'b0;
        @(negedge clk);
        check_byte(data_to_transmit, exp, "sync byte");
    endtask

    task automatic test_sync_byte();
        send_sync(1'b1, 1'b1, 8'hC8);
        send_sync(1'b1, 1'b0, 8'hC8);
        send_sync(1'b0, 1'b1, 8'h48);
        send_sync(1'b0, 1'b0, 8'h08);
    endtask

    task automatic test_solo_match();
        logic [5:0] goals;
        score_t     exp_enemy;
        exp_enemy = 0;
        draw_goals(goals);
        @(posedge clk);
        solo_enable <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_mode(game_mode, SOLO, "mode with solo_enable");
        click_left();
        check_state(game_state, KEEPER, "solo state after click");
        for (int i = 0; i < 6; i++) begin
            if (goals[i]) begin
                exp_enemy++;
            end
            take_shot(goals[i]);
            check_state(game_state, KEEPER, "solo state after shot");
            check_score(goals_enemy, exp_enemy, "solo goals_enemy");
            check_score(goals_own, 0, "solo goals_own");
        end
        wait_state(exp_enemy < 2 ? WINNER : LOSER, 3);
        click_right();
        check_state(game_state, START, "state after solo match");
        @(posedge clk);
        @(negedge clk);
        check_score(goals_enemy, 0, "goals_enemy cleared in START");
    endtask

    task automatic test_multi_match(input logic [5:0] goals);
        g_state exp_state;
        score_t exp_own;
        score_t exp_enemy;
        exp_own   = 0;
        exp_enemy = 0;
        start_multi(1'b1);
        exp_state = SHOOTER;
        for (int i = 0; i < 6; i++) begin
            if (goals[i] && exp_state == SHOOTER) begin
                exp_own++;
            end else if (goals[i]) begin
                exp_enemy++;
            end
            take_shot(goals[i]);
            exp_state = (exp_state == SHOOTER) ? KEEPER : SHOOTER;
            check_state(game_state, exp_state, "multi state after shot");
            check_score(goals_own, exp_own, "multi goals_own");
            check_score(goals_enemy, exp_enemy, "multi goals_enemy");
            if (i == 2) begin
                @(posedge clk);
                solo_enable <= 1'b1;
                @(posedge clk);
                solo_enable <= 1'b0;
                @(negedge clk);
                check_mode(game_mode, MULTI, "mode during match");
            end
        end
        // A tie is a loss
        wait_state(exp_own > exp_enemy ? WINNER : LOSER, 3);
        click_right();
        check_state(game_state, START, "state after multi match");
    endtask

    task automatic test_window_expiry();
        start_multi(1'b1);
        // A scored flag without a shot attempt is not a goal
        @(posedge clk);
        shot_scored <= 1'b1;
        @(negedge clk);
        wait_state(KEEPER, 16 + 1);
        check_score(goals_own, 0, "goals_own after expiry");
        check_score(goals_enemy, 0, "goals_enemy after expiry");
        @(posedge clk);
        shot_scored <= 1'b0;
        @(negedge clk);
    endtask

    task automatic test_link_loss();
        check_state(game_state, KEEPER, "state before link loss");
        take_shot(1'b1);
        take_shot(1'b1);
        check_score(goals_own, 1, "goals_own before link loss");
        check_score(goals_enemy, 1, "goals_enemy before link loss");
        @(posedge clk);
        connect_corrected <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_state(game_state, START, "state after link loss");
        @(posedge clk);
        @(negedge clk);
        check_score(goals_own, 0, "goals_own after link loss");
        check_score(goals_enemy, 0, "goals_enemy after link loss");
    endtask

    initial begin
        logic [5:0] goals;
        clk               = 1'b0;
        rst               = 1'b1;
        left_clicked      = 1'b0;
        right_clicked     = 1'b0;
        solo_enable       = 1'b0;
        connect_corrected = 1'b0;
        enemy_shooter     = 1'b0;
        game_starts       = 1'b0;
        shot_taken        = 1'b0;
        shot_scored       = 1'b0;
        mismatches        = 0;
        failures          = 0;
        cycles            = 0;
        lfsr_state        = 8'd66;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_reset();
        test_sync_byte();
        test_solo_match();
        draw_goals(goals);
        test_multi_match(goals);
        // One goal on each side ends level
        test_multi_match(6'b000011);
        test_window_expiry();
        test_link_loss();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* game_core.f */
rtl/game_pkg.sv
rtl/shot_if.sv
rtl/game_state_sel.sv
rtl/shot_timer.sv
rtl/match_scorer.sv
rtl/game_core.sv
dv/game_core_tb.sv

/* Bender.yml */
package:
  name: game_core

sources:
  - files:
      - rtl/game_pkg.sv
      - rtl/shot_if.sv
      - rtl/game_state_sel.sv
      - rtl/shot_timer.sv
      - rtl/match_scorer.sv
      - rtl/game_core.sv
  - target: simulation
    files:
      - dv/game_core_tb.sv
